// ==== design/ebPkg.sv ====
// *********************************************************************
// Shared types and constants for the execution box control path.
// Little-endian only. Opcode values follow the Alpha major opcode map.
// The control word layout is fixed by the field widths below, packed
// from nShift down to the overflow-trap bit.
// *********************************************************************
package ebPkg;

  typedef logic [31:0] instWord;
  typedef logic [63:0] dataWord;
  typedef logic [4:0]  regAddr;
  typedef logic [5:0]  opcodeT;
  typedef logic [6:0]  funcT;

  // Control word fields, MSB first
  localparam int nShiftW  = 6;
  localparam int shifterW = 2;
  localparam int aluW     = 4;
  localparam int cmpW     = 3;
  localparam int meiW     = 5;
  localparam int xorW     = 3;
  localparam int mux0W    = 1;
  localparam int mux1W    = 1;
  localparam int mux2W    = 3;
  localparam int mux3W    = 2;
  localparam int ovfW     = 1;

  typedef logic [nShiftW + shifterW + aluW + cmpW + meiW + xorW
                 + mux0W + mux1W + mux2W + mux3W + ovfW - 1:0] ctrlWord;

  localparam opcodeT opJump        = 6'h1A; // JMP/JSR/RET group
  localparam opcodeT opArith       = 6'h10;
  localparam opcodeT opLogic       = 6'h11; // Includes conditional moves
  localparam opcodeT opStoreCondL  = 6'h2E;
  localparam opcodeT opStoreCondQ  = 6'h2F;
  localparam opcodeT opLoadLockedL = 6'h2A;
  localparam opcodeT opLoadLockedQ = 6'h2B;

  // Bubble inserted after control transfers
  localparam instWord nopInst = 32'h0000_0000;

endpackage

// ==== design/branchCompare.sv ====
// *********************************************************************
// Branch condition on register A, keyed by opcode bits 3:0.
// Ops 0 and 4 (BR, BSR) always take. Floating-point branch codes are
// not supported and resolve as not taken.
// *********************************************************************
`timescale 1ns/1ps

module branchCompare (
  input  ebPkg::dataWord a,
  input  logic [3:0]     op,
  output logic           taken
);

  logic negative;
  logic zero;

  assign negative = a[63];
  assign zero = ~(|a);

  always_comb begin
    case (op)
      4'h0, 4'h4: taken = 1'b1;          // Unconditional
      4'h8:       taken = ~a[0];         // BLBC
      4'h9:       taken = zero;          // BEQ
      4'hA:       taken = negative;      // BLT
      4'hB:       taken = zero | negative;
      4'hC:       taken = a[0];          // BLBS
      4'hD:       taken = ~zero;         // BNE
      4'hE:       taken = zero | ~negative;
      4'hF:       taken = ~zero & ~negative; // BGT
      default:    taken = 1'b0;
    endcase
  end

endmodule

// ==== design/issueStage.sv ====
// *********************************************************************
// PC generation and stage-2 field extraction.
// resetPc must be word aligned. A jump or branch in stage 2 always
// costs one bubble; there is no prediction and no stall input.
// *********************************************************************
`timescale 1ns/1ps

module issueStage #(
  parameter ebPkg::dataWord resetPc = '0
) (
  input  logic           clk,
  input  logic           reset,
  input  ebPkg::instWord inst2,
  input  ebPkg::dataWord regReadA,
  input  ebPkg::dataWord regReadB,
  output ebPkg::dataWord pc,
  output ebPkg::dataWord pc2,
  output logic           bubble,
  output logic [1:0]     irfM1Sel,
  output logic           irfM2Sel,
  output logic [7:0]     literal,
  output logic [15:0]    displacement,
  output ebPkg::regAddr  raAddr,
  output ebPkg::regAddr  rbAddr
);

  logic           jump;
  logic           branch;
  logic           taken;
  ebPkg::dataWord pcPlus4;
  ebPkg::dataWord pcPlus4Q;     // PC+4 of the instruction now in stage 2
  ebPkg::dataWord branchTarget;
  ebPkg::dataWord jumpTarget;
  ebPkg::dataWord pcNext;

  assign jump = inst2[31:26] == ebPkg::opJump;
  assign branch = inst2[31:30] == 2'b11; // Opcodes 30 to 3F
  assign bubble = jump | branch;

  // On a bubble the fall-through restarts from the stage-2 address
  assign pcPlus4 = (bubble ? pc2 : pc) + 64'd4;
  assign branchTarget = pcPlus4Q + {{41{inst2[20]}}, inst2[20:0], 2'b00};
  assign jumpTarget = {regReadB[63:2], 2'b00};

  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branch && taken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= resetPc;
      pc2 <= resetPc;
    end else begin
      pc <= pcNext;
      pc2 <= pc;
    end
  end

  always_ff @(posedge clk) begin
    pcPlus4Q <= pcPlus4;
  end

  branchCompare uBranchCompare (
    .a     (regReadA),
    .op    (inst2[29:26]),
    .taken (taken)
  );

  assign irfM1Sel = {jump, ~inst2[30]};
  assign irfM2Sel = inst2[12]; // Literal form of operate
  assign literal = inst2[20:13];
  assign displacement = inst2[15:0];
  assign raAddr = inst2[25:21];
  assign rbAddr = inst2[20:16];

  // Alignment survives every next-PC path once reset has loaded resetPc
  pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== design/pipeTrack.sv ====
// *********************************************************************
// Instruction shadow for stages 2 to 5 with late-stage decodes.
// Every stage advances on each clock. Memory write and the locked
// pair are taken from stage 4, write-back controls from stage 5.
// *********************************************************************
`timescale 1ns/1ps

module pipeTrack (
  input  logic           clk,
  input  logic           reset,
  input  ebPkg::instWord inst,
  input  logic           bubble,
  output ebPkg::instWord inst2,
  output ebPkg::instWord inst3,
  output logic           regWrite,
  output logic           memWrite,
  output logic           storeCond,
  output logic           loadLocked,
  output logic [1:0]     mboxM1Sel,
  output logic           mboxM2Sel,
  output logic           mboxM3Sel,
  output ebPkg::regAddr  raAddrWb,
  output ebPkg::regAddr  rcAddrWb
);

  ebPkg::instWord inst4;
  ebPkg::instWord inst5;
  ebPkg::opcodeT  op4;
  ebPkg::opcodeT  op5;
  logic           storeCond5;
  logic           jump5;
  logic           cmov;

  always_ff @(posedge clk) begin
    if (reset) begin
      inst2 <= ebPkg::nopInst;
      inst3 <= ebPkg::nopInst;
      inst4 <= ebPkg::nopInst;
      inst5 <= ebPkg::nopInst;
    end else begin
      inst2 <= bubble ? ebPkg::nopInst : inst; // Squash the fall-through fetch
      inst3 <= inst2;
      inst4 <= inst3;
      inst5 <= inst4;
    end
  end

  assign op4 = inst4[31:26];
  assign op5 = inst5[31:26];

  // Stage 4
  assign memWrite = op4 inside {[6'h0D:6'h0F], 6'h2C, 6'h2D};
  assign storeCond = op4 inside {ebPkg::opStoreCondL, ebPkg::opStoreCondQ};
  assign loadLocked = op4 inside {ebPkg::opLoadLockedL, ebPkg::opLoadLockedQ};

  // Stage 5
  assign regWrite = op5 inside {[6'h08:6'h0C], ebPkg::opArith, ebPkg::opLogic,
                                [6'h28:6'h2B]};
  assign storeCond5 = op5 inside {ebPkg::opStoreCondL, ebPkg::opStoreCondQ};
  assign jump5 = op5 == ebPkg::opJump;
  assign cmov = (op5 == ebPkg::opLogic) && (inst5[8:5] == 4'h4 || inst5[8:5] == 4'h6);

  assign mboxM1Sel = {cmov | storeCond5, ~inst5[30] | storeCond5};
  assign mboxM2Sel = ~inst5[30] | jump5; // Return address on jumps
  assign mboxM3Sel = cmov;
  assign raAddrWb = inst5[25:21];
  assign rcAddrWb = inst5[4:0];

  // The squashed slot must not look like a control transfer to the issue stage
  bubbleSquash: assert property (@(posedge clk) disable iff (reset)
    bubble |=> inst2 == ebPkg::nopInst && !bubble);

endmodule

// ==== design/operateDecode.sv ====
// *********************************************************************
// Stage-3 decode to the execution control word.
// Covers memory format 08-0F and 28-2F, arithmetic 10 and logic 11.
// Shifter, mei, mux0 and mux3 are only used by unsupported groups and
// stay zero. Any other opcode or function decodes to zero.
// *********************************************************************
`timescale 1ns/1ps

module operateDecode (
  input  ebPkg::instWord inst3,
  output ebPkg::ctrlWord ctrl
);

  ebPkg::opcodeT opcode;
  ebPkg::funcT   func;

  function automatic ebPkg::ctrlWord ctrlFields(
    input logic [ebPkg::nShiftW-1:0] nShift,
    input logic [ebPkg::aluW-1:0]    alu,
    input logic [ebPkg::cmpW-1:0]    cmp,
    input logic [ebPkg::xorW-1:0]    xorSel,
    input logic [ebPkg::mux1W-1:0]   mux1,
    input logic [ebPkg::mux2W-1:0]   mux2,
    input logic [ebPkg::ovfW-1:0]    ovf
  );
    return {nShift, {ebPkg::shifterW{1'b0}}, alu, cmp, {ebPkg::meiW{1'b0}}, xorSel,
            {ebPkg::mux0W{1'b0}}, mux1, mux2, {ebPkg::mux3W{1'b0}}, ovf};
  endfunction

  assign opcode = inst3[31:26];
  assign func = inst3[11:5];

  // Argument order: nShift, alu, cmp, xor, mux1, mux2, overflow trap
  always_comb begin
    ctrl = '0;
    case (opcode)
      6'h08: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // LDA
      6'h09: ctrl = ctrlFields(6'h10, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // LDAH
      6'h0A: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h7, 1'b0, 3'h0, 1'b0); // LDBU
      6'h0B: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h0, 1'b0, 3'h3, 1'b0); // LDQ_U
      6'h0C: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h6, 1'b0, 3'h0, 1'b0); // LDWU
      6'h0D: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h6, 1'b0, 3'h0, 1'b0); // STW
      6'h0E: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h7, 1'b0, 3'h0, 1'b0); // STB
      6'h0F: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h0, 1'b0, 3'h3, 1'b0); // STQ_U
      6'h28: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h4, 1'b0, 3'h0, 1'b0); // LDL
      6'h29: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // LDQ
      6'h2A: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h4, 1'b0, 3'h0, 1'b0); // LDL_L
      6'h2B: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // LDQ_L
      6'h2C: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h4, 1'b0, 3'h0, 1'b0); // STL
      6'h2D: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // STQ
      6'h2E: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h4, 1'b0, 3'h0, 1'b0); // STL_C
      6'h2F: ctrl = ctrlFields(6'h00, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // STQ_C
      ebPkg::opArith: begin
        case (func)
          7'h00: ctrl = ctrlFields(6'h0, 4'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0); // ADDL
          7'h02: ctrl = ctrlFields(6'h2, 4'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0); // S4ADDL
          7'h09: ctrl = ctrlFields(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0); // SUBL
          7'h0B: ctrl = ctrlFields(6'h2, 4'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0); // S4SUBL
          7'h0F: ctrl = ctrlFields(6'h0, 4'h6, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // CMPBGE
          7'h12: ctrl = ctrlFields(6'h3, 4'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0); // S8ADDL
          7'h1B: ctrl = ctrlFields(6'h3, 4'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0); // S8SUBL
          7'h1D: ctrl = ctrlFields(6'h0, 4'h2, 3'h5, 3'h0, 1'b0, 3'h2, 1'b0); // CMPULT
          7'h20: ctrl = ctrlFields(6'h0, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // ADDQ
          7'h22: ctrl = ctrlFields(6'h2, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // S4ADDQ
          7'h29: ctrl = ctrlFields(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // SUBQ
          7'h2B: ctrl = ctrlFields(6'h2, 4'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // S4SUBQ
          7'h2D: ctrl = ctrlFields(6'h0, 4'h2, 3'h2, 3'h0, 1'b0, 3'h2, 1'b0); // CMPEQ
          7'h32: ctrl = ctrlFields(6'h3, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // S8ADDQ
          7'h3B: ctrl = ctrlFields(6'h3, 4'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // S8SUBQ
          7'h3D: ctrl = ctrlFields(6'h0, 4'h2, 3'h6, 3'h0, 1'b0, 3'h2, 1'b0); // CMPULE
          7'h40: ctrl = ctrlFields(6'h0, 4'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b1); // ADDL/V
          7'h49: ctrl = ctrlFields(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b1); // SUBL/V
          7'h4D: ctrl = ctrlFields(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0); // CMPLT
          7'h60: ctrl = ctrlFields(6'h0, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b1); // ADDQ/V
          7'h69: ctrl = ctrlFields(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b1); // SUBQ/V
          7'h6D: ctrl = ctrlFields(6'h0, 4'h2, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0); // CMPLE
          default: ctrl = '0;
        endcase
      end
      ebPkg::opLogic: begin
        case (func)
          7'h00: ctrl = ctrlFields(6'h00, 4'h3, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // AND
          7'h08: ctrl = ctrlFields(6'h00, 4'h3, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0); // BIC
          7'h14: ctrl = ctrlFields(6'h3F, 4'h0, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0); // CMOVLBS
          7'h16: ctrl = ctrlFields(6'h3F, 4'h0, 3'h2, 3'h0, 1'b0, 3'h2, 1'b0); // CMOVLBC
          7'h20: ctrl = ctrlFields(6'h00, 4'h4, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // BIS
          7'h24: ctrl = ctrlFields(6'h00, 4'h0, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0); // CMOVEQ
          7'h26: ctrl = ctrlFields(6'h00, 4'h0, 3'h7, 3'h0, 1'b0, 3'h2, 1'b0); // CMOVNE
          7'h28: ctrl = ctrlFields(6'h00, 4'h4, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0); // ORNOT
          7'h40: ctrl = ctrlFields(6'h00, 4'h5, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0); // XOR
          7'h44: ctrl = ctrlFields(6'h00, 4'h0, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0); // CMOVLT
          7'h46: ctrl = ctrlFields(6'h00, 4'h0, 3'h4, 3'h0, 1'b0, 3'h2, 1'b0); // CMOVGE
          7'h48: ctrl = ctrlFields(6'h00, 4'h5, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0); // EQV
          7'h64: ctrl = ctrlFields(6'h00, 4'h0, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0); // CMOVLE
          7'h66: ctrl = ctrlFields(6'h00, 4'h0, 3'h1, 3'h0, 1'b0, 3'h2, 1'b0); // CMOVGT
          default: ctrl = '0;
        endcase
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== design/executeControl.sv ====
// *********************************************************************
// Execution box control, top level.
// Lockstep pipeline with no stall; up to four instructions in flight.
// inst and the register read data are expected from outside each cycle.
// *********************************************************************
`timescale 1ns/1ps

module executeControl #(
  parameter ebPkg::dataWord resetPc = '0
) (
  input  logic           clk,
  input  logic           reset,
  input  ebPkg::instWord inst,
  input  ebPkg::dataWord regReadA,
  input  ebPkg::dataWord regReadB,
  output ebPkg::dataWord pc,
  output ebPkg::dataWord pc2,
  output logic [1:0]     irfM1Sel,
  output logic           irfM2Sel,
  output logic [7:0]     literal,
  output logic [15:0]    displacement,
  output ebPkg::regAddr  raAddr,
  output ebPkg::regAddr  rbAddr,
  output ebPkg::ctrlWord ctrl,
  output logic           regWrite,
  output logic           memWrite,
  output logic           storeCond,
  output logic           loadLocked,
  output logic [1:0]     mboxM1Sel,
  output logic           mboxM2Sel,
  output logic           mboxM3Sel,
  output ebPkg::regAddr  raAddrWb,
  output ebPkg::regAddr  rcAddrWb
);

  ebPkg::instWord inst2;
  ebPkg::instWord inst3;
  logic           bubble;

  issueStage #(
    .resetPc (resetPc)
  ) uIssueStage (
    .clk          (clk),
    .reset        (reset),
    .inst2        (inst2),
    .regReadA     (regReadA),
    .regReadB     (regReadB),
    .pc           (pc),
    .pc2          (pc2),
    .bubble       (bubble),
    .irfM1Sel     (irfM1Sel),
    .irfM2Sel     (irfM2Sel),
    .literal      (literal),
    .displacement (displacement),
    .raAddr       (raAddr),
    .rbAddr       (rbAddr)
  );

  pipeTrack uPipeTrack (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .bubble     (bubble),
    .inst2      (inst2),
    .inst3      (inst3),
    .regWrite   (regWrite),
    .memWrite   (memWrite),
    .storeCond  (storeCond),
    .loadLocked (loadLocked),
    .mboxM1Sel  (mboxM1Sel),
    .mboxM2Sel  (mboxM2Sel),
    .mboxM3Sel  (mboxM3Sel),
    .raAddrWb   (raAddrWb),
    .rcAddrWb   (rcAddrWb)
  );

  operateDecode uOperateDecode (
    .inst3 (inst3),
    .ctrl  (ctrl)
  );

endmodule

// ==== sim/clockGen.sv ====
// *********************************************************************
// Testbench clock and reset source.
// reset is high from time zero and drops 2 ns after the last reset edge.
// *********************************************************************
`timescale 1ns/1ps

module clockGen #(
  parameter int period = 40,
  parameter int resetCycles = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #2 reset = 1'b0; // Same offset as the stimulus
  end

endmodule

// ==== sim/tbExecuteControl.sv ====
// *********************************************************************
// Testbench for the execution box control path.
// Plays instruction memory and register file with seeded random data
// and checks every output each cycle against a cycle model.
// Branches use only the supported condition codes 0, 4 and 8 to F.
// *********************************************************************
`timescale 1ns/1ps

module tbExecuteControl;

  localparam int period = 40;
  localparam int numCycles = 2000;
  localparam int timeoutNs = (numCycles + 100) * period;
  localparam ebPkg::dataWord resetPc = 64'h0000_0000_0001_0000;

  logic           clk;
  logic           reset;
  ebPkg::instWord inst;
  ebPkg::dataWord regReadA;
  ebPkg::dataWord regReadB;
  ebPkg::dataWord pc;
  ebPkg::dataWord pc2;
  logic [1:0]     irfM1Sel;
  logic           irfM2Sel;
  logic [7:0]     literal;
  logic [15:0]    displacement;
  ebPkg::regAddr  raAddr;
  ebPkg::regAddr  rbAddr;
  ebPkg::ctrlWord ctrl;
  logic           regWrite;
  logic           memWrite;
  logic           storeCond;
  logic           loadLocked;
  logic [1:0]     mboxM1Sel;
  logic           mboxM2Sel;
  logic           mboxM3Sel;
  ebPkg::regAddr  raAddrWb;
  ebPkg::regAddr  rcAddrWb;

  ebPkg::dataWord modelPc;
  ebPkg::dataWord modelPc2;
  ebPkg::instWord shadow2;   // Instruction shadow for stages 2 to 5
  ebPkg::instWord shadow3;
  ebPkg::instWord shadow4;
  ebPkg::instWord shadow5;
  int             errors;

  clockGen #(.period(period), .resetCycles(2)) uClockGen (.clk(clk), .reset(reset));

  executeControl #(.resetPc(resetPc)) u_dut (.*);

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Fields MSB first are nShift, shifter, alu, cmp, mei, xor, mux0, mux1, mux2, mux3, trap
  function automatic logic [30:0] packCtrl(input logic [5:0] nShift, input logic [3:0] alu,
                                           input logic [2:0] cmp, input logic [2:0] xorSel,
                                           input logic mux1, input logic [2:0] mux2,
                                           input logic ovf);
    return {nShift, 2'b00, alu, cmp, 5'b00000, xorSel, 1'b0, mux1, mux2, 2'b00, ovf};
  endfunction

  function automatic logic [30:0] expectedCtrl(input ebPkg::instWord i);
    logic [5:0] op;
    logic [6:0] fn;
    logic [2:0] xorSel;
    op = i[31:26];
    fn = i[11:5];
    if (op inside {[6'h08:6'h0F], [6'h28:6'h2F]}) begin
      case (op)
        6'h0A, 6'h0E: xorSel = 3'd7;             // Byte
        6'h0C, 6'h0D: xorSel = 3'd6;             // Word
        6'h28, 6'h2A, 6'h2C, 6'h2E: xorSel = 3'd4;
        default: xorSel = 3'd0;                  // Quad
      endcase
      // LDAH shifts its displacement up by 16
      return packCtrl(op == 6'h09 ? 6'h10 : 6'h00, 4'h1, 3'h0, xorSel, 1'b0,
                      (op == 6'h0B || op == 6'h0F) ? 3'h3 : 3'h0, 1'b0);
    end
    if (op == 6'h10) begin
      case (fn)
        7'h00: return packCtrl(6'h0, 4'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);
        7'h02: return packCtrl(6'h2, 4'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);
        7'h09: return packCtrl(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);
        7'h0B: return packCtrl(6'h2, 4'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);
        7'h0F: return packCtrl(6'h0, 4'h6, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h12: return packCtrl(6'h3, 4'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);
        7'h1B: return packCtrl(6'h3, 4'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);
        7'h1D: return packCtrl(6'h0, 4'h2, 3'h5, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h20: return packCtrl(6'h0, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h22: return packCtrl(6'h2, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h29: return packCtrl(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h2B: return packCtrl(6'h2, 4'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h2D: return packCtrl(6'h0, 4'h2, 3'h2, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h32: return packCtrl(6'h3, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h3B: return packCtrl(6'h3, 4'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h3D: return packCtrl(6'h0, 4'h2, 3'h6, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h40: return packCtrl(6'h0, 4'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b1); // Trapping add
        7'h49: return packCtrl(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b1);
        7'h4D: return packCtrl(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h60: return packCtrl(6'h0, 4'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b1);
        7'h69: return packCtrl(6'h0, 4'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b1);
        7'h6D: return packCtrl(6'h0, 4'h2, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0);
        default: return '0;
      endcase
    end
    if (op == 6'h11) begin
      case (fn)
        7'h00: return packCtrl(6'h00, 4'h3, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h08: return packCtrl(6'h00, 4'h3, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0);
        7'h14: return packCtrl(6'h3F, 4'h0, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0); // Low-bit cmov
        7'h16: return packCtrl(6'h3F, 4'h0, 3'h2, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h20: return packCtrl(6'h00, 4'h4, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h24: return packCtrl(6'h00, 4'h0, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h26: return packCtrl(6'h00, 4'h0, 3'h7, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h28: return packCtrl(6'h00, 4'h4, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0);
        7'h40: return packCtrl(6'h00, 4'h5, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);
        7'h44: return packCtrl(6'h00, 4'h0, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h46: return packCtrl(6'h00, 4'h0, 3'h4, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h48: return packCtrl(6'h00, 4'h5, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0);
        7'h64: return packCtrl(6'h00, 4'h0, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0);
        7'h66: return packCtrl(6'h00, 4'h0, 3'h1, 3'h0, 1'b0, 3'h2, 1'b0);
        default: return '0;
      endcase
    end
    return '0;
  endfunction

  function automatic logic branchTaken(input logic [3:0] cond, input ebPkg::dataWord a);
    logic signed [63:0] value;
    value = a;
    case (cond)
      4'h0, 4'h4: return 1'b1;
      4'h8: return !a[0];
      4'h9: return value == 64'sd0;
      4'hA: return value < 64'sd0;
      4'hB: return value <= 64'sd0;
      4'hC: return a[0];
      4'hD: return value != 64'sd0;
      4'hE: return value >= 64'sd0;
      4'hF: return value > 64'sd0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ebPkg::instWord randomInst();
    ebPkg::instWord i;
    int unsigned    pick;
    int unsigned    k;
    i = $urandom;
    pick = $urandom % 100;
    k = $urandom;
    if (pick < 30) begin
      k = k % 16;
      i[31:26] = k < 8 ? 6'(8 + k) : 6'(32'h28 + k - 8); // Memory format
    end else if (pick < 60) begin
      i[31:26] = k[0] ? 6'h10 : 6'h11;
      // Mostly defined functions and a few undefined ones
      while (k[3:1] != 3'd0 && expectedCtrl(i) == 31'd0) begin
        i[11:5] = 7'($urandom);
      end
    end else if (pick < 75) begin
      k = k % 24;
      i[31:26] = k < 8 ? 6'(k) : (k < 16 ? 6'(32'h12 + k - 8) : 6'(32'h20 + k - 16));
    end else if (pick < 85) begin
      i[31:26] = 6'h1A;
    end else begin
      k = k % 10;
      i[31:26] = {2'b11, k < 2 ? 4'(k * 4) : 4'(k + 6)}; // Conditions 0, 4, 8 to F
    end
    return i;
  endfunction

  task automatic driveInputs;
    int unsigned kind;
    kind = $urandom % 4;
    inst = randomInst();
    regReadB = {$urandom, $urandom};
    case (kind)
      0: regReadA = '0;
      1: regReadA = {1'b1, 31'($urandom), $urandom};   // Negative
      2: regReadA = {32'd0, $urandom | 32'd1};         // Odd positive
      default: regReadA = {$urandom, $urandom};
    endcase
  endtask

  // One clock edge of the model with the inputs held during the cycle
  task automatic stepModel;
    logic           jump;
    logic           branch;
    ebPkg::dataWord nextPc;
    jump = shadow2[31:26] == 6'h1A;
    branch = shadow2[31:30] == 2'b11;
    if (jump) begin
      nextPc = {regReadB[63:2], 2'b00};
    end else if (branch && branchTaken(shadow2[29:26], regReadA)) begin
      // modelPc2 is the address of the branch in stage 2
      nextPc = modelPc2 + 64'd4 + {{41{shadow2[20]}}, shadow2[20:0], 2'b00};
    end else if (branch) begin
      nextPc = modelPc2 + 64'd4;
    end else begin
      nextPc = modelPc + 64'd4;
    end
    modelPc2 = modelPc;
    modelPc = nextPc;
    shadow5 = shadow4;
    shadow4 = shadow3;
    shadow3 = shadow2;
    shadow2 = (jump || branch) ? ebPkg::nopInst : inst;
  endtask

  task automatic checkOutputs;
    logic [5:0] op4;
    logic [5:0] op5;
    logic       storeCond5;
    logic       cmov;
    op4 = shadow4[31:26];
    op5 = shadow5[31:26];
    storeCond5 = op5 inside {6'h2E, 6'h2F};
    cmov = op5 == 6'h11 && shadow5[8:5] inside {4'h4, 4'h6};
    checkValue("pc", modelPc, pc);
    checkValue("pc2", modelPc2, pc2);
    checkValue("raAddr", 64'(shadow2[25:21]), 64'(raAddr));
    checkValue("rbAddr", 64'(shadow2[20:16]), 64'(rbAddr));
    checkValue("literal", 64'(shadow2[20:13]), 64'(literal));
    checkValue("displacement", 64'(shadow2[15:0]), 64'(displacement));
    checkValue("irfM1Sel", 64'({shadow2[31:26] == 6'h1A, ~shadow2[30]}), 64'(irfM1Sel));
    checkValue("irfM2Sel", 64'({shadow2[12]}), 64'(irfM2Sel));
    checkValue("ctrl", 64'(expectedCtrl(shadow3)), 64'(ctrl));
    checkValue("memWrite", 64'({op4 inside {[6'h0D:6'h0F], 6'h2C, 6'h2D}}), 64'(memWrite));
    checkValue("storeCond", 64'({op4 inside {6'h2E, 6'h2F}}), 64'(storeCond));
    checkValue("loadLocked", 64'({op4 inside {6'h2A, 6'h2B}}), 64'(loadLocked));
    checkValue("regWrite", 64'({op5 inside {[6'h08:6'h0C], 6'h10, 6'h11, [6'h28:6'h2B]}}),
               64'(regWrite));
    checkValue("mboxM1Sel", 64'({cmov | storeCond5, ~shadow5[30] | storeCond5}),
               64'(mboxM1Sel));
    checkValue("mboxM2Sel", 64'({~shadow5[30] | (op5 == 6'h1A)}), 64'(mboxM2Sel));
    checkValue("mboxM3Sel", 64'({cmov}), 64'(mboxM3Sel));
    checkValue("raAddrWb", 64'(shadow5[25:21]), 64'(raAddrWb));
    checkValue("rcAddrWb", 64'(shadow5[4:0]), 64'(rcAddrWb));
  endtask

  initial begin
    errors = 0;
    inst = {6'h10, 5'd1, 5'd2, 3'd0, 1'b0, 7'h20, 5'd3}; // ADDQ held under reset
    regReadA = '0;
    regReadB = '0;
    void'($urandom(32'hd68b));
    modelPc = resetPc;
    modelPc2 = resetPc;
    shadow2 = ebPkg::nopInst;
    shadow3 = ebPkg::nopInst;
    shadow4 = ebPkg::nopInst;
    shadow5 = ebPkg::nopInst;
    @(negedge reset);
    checkOutputs(); // State left by reset
    repeat (numCycles) begin
      driveInputs();
      @(posedge clk);
      stepModel();
      #1;
      checkOutputs();
      #1;
    end
    $display("Finished %0d cycles with %0d errors", numCycles, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(timeoutNs);
    $display("Watchdog expired before the stimulus loop completed");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== ebox.f ====
design/ebPkg.sv
design/branchCompare.sv
design/issueStage.sv
design/pipeTrack.sv
design/operateDecode.sv
design/executeControl.sv
sim/clockGen.sv
sim/tbExecuteControl.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbExecuteControl -f ebox.f -o simEbox
./obj_dir/simEbox > sim.log
cat sim.log
if grep -q "TEST OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
